//--- Bender.yml
package:
  name: packet_switch

sources:
  - switch_pkg.sv
  - fifo_mem.sv
  - fifo.sv
  - rr_arbiter.sv
  - wb_switch_regs.sv
  - packet_switch.sv
  - target: test
    files:
      - tb_packet_switch.sv

//--- compile.f
switch_pkg.sv
fifo_mem.sv
fifo.sv
rr_arbiter.sv
wb_switch_regs.sv
packet_switch.sv
tb_packet_switch.sv

//--- fifo.sv
// Eight-entry flit FIFO
// Registered pop data and status flags derived from the fill count
`timescale 1ns/1ns

module fifo (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           write,
    input  switch_pkg::flit_t              data_in,
    input  logic                           read,
    input  logic [switch_pkg::COUNT_W-1:0] afull_level,
    input  logic [switch_pkg::COUNT_W-1:0] aempty_level,
    output switch_pkg::flit_t              data_out,
    output switch_pkg::fifo_status_t       status
);

    logic [switch_pkg::COUNT_W-1:0] count;
    logic [switch_pkg::PTR_W-1:0]   wr_ptr;
    logic [switch_pkg::PTR_W-1:0]   rd_ptr;
    switch_pkg::flit_t              head;
    logic                           do_write;
    logic                           do_read;

    assign do_write = write && !status.full;
    assign do_read = read && !status.empty;

    fifo_mem u_mem (
        .clk      (clk),
        .write    (do_write),
        .wr_ptr   (wr_ptr),
        .data_in  (data_in),
        .rd_ptr   (rd_ptr),
        .data_out (head)
    );

    // Flags straight from the count
    always_comb begin
        status = '0;
        status.empty = (count == '0);
        status.full = (count == switch_pkg::COUNT_W'(switch_pkg::FIFO_DEPTH));
        status.almost_full = (count >= afull_level);
        status.pause = (count >= afull_level);
        status.almost_empty = (count != '0) && (count <= aempty_level);
        // Overflow or underflow attempt lasting one cycle
        status.error = (write && status.full) || (read && status.empty);
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Write and read together keep the count
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Pop data holds until the next accepted read
    always_ff @(posedge clk) begin
        if (!reset) begin
            data_out <= '0;
        end else if (do_read) begin
            data_out <= head;
        end
    end

endmodule

//--- fifo_mem.sv
// FIFO storage array
// Written at the write pointer, read combinationally at the read pointer
`timescale 1ns/1ns

module fifo_mem (
    input  logic                         clk,
    input  logic                         write,
    input  logic [switch_pkg::PTR_W-1:0] wr_ptr,
    input  switch_pkg::flit_t            data_in,
    input  logic [switch_pkg::PTR_W-1:0] rd_ptr,
    output switch_pkg::flit_t            data_out
);

    switch_pkg::flit_t mem [switch_pkg::FIFO_DEPTH];

    // Caller gates write with not-full
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem[rd_ptr];

endmodule

//--- packet_switch.sv
// Four-port packet switch top
// Input FIFOs, round-robin arbiter, output FIFOs and Wishbone registers
`timescale 1ns/1ns

module packet_switch (
    input  logic                             clk,
    input  logic                             reset,
    input  switch_pkg::push_t                push [switch_pkg::NUM_PORTS],
    output logic [switch_pkg::NUM_PORTS-1:0] in_pause,
    input  logic [switch_pkg::NUM_PORTS-1:0] pop_read,
    output switch_pkg::flit_t                pop_data [switch_pkg::NUM_PORTS],
    output logic [switch_pkg::NUM_PORTS-1:0] pop_empty,
    input  switch_pkg::wb_req_t              wb_in,
    output switch_pkg::wb_rsp_t              wb_out
);

    switch_pkg::fifo_status_t         in_status [switch_pkg::NUM_PORTS];
    switch_pkg::fifo_status_t         out_status [switch_pkg::NUM_PORTS];
    switch_pkg::flit_t                in_flit [switch_pkg::NUM_PORTS];
    logic [switch_pkg::NUM_PORTS-1:0] arb_read;
    logic [switch_pkg::NUM_PORTS-1:0] arb_write;
    switch_pkg::flit_t                arb_flit;
    logic                             enable;
    logic [switch_pkg::COUNT_W-1:0]   afull_level;
    logic [switch_pkg::COUNT_W-1:0]   aempty_level;

    for (genvar i = 0; i < switch_pkg::NUM_PORTS; i++) begin : g_port
        fifo u_in_fifo (
            .clk          (clk),
            .reset        (reset),
            .write        (push[i].write),
            .data_in      (push[i].flit),
            .read         (arb_read[i]),
            .afull_level  (afull_level),
            .aempty_level (aempty_level),
            .data_out     (in_flit[i]),
            .status       (in_status[i])
        );

        // All outputs share the arbiter's flit bus
        fifo u_out_fifo (
            .clk          (clk),
            .reset        (reset),
            .write        (arb_write[i]),
            .data_in      (arb_flit),
            .read         (pop_read[i]),
            .afull_level  (afull_level),
            .aempty_level (aempty_level),
            .data_out     (pop_data[i]),
            .status       (out_status[i])
        );

        assign in_pause[i] = in_status[i].pause;
        assign pop_empty[i] = out_status[i].empty;
    end

    rr_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .in_status  (in_status),
        .in_flit    (in_flit),
        .in_read    (arb_read),
        .out_status (out_status),
        .out_write  (arb_write),
        .out_flit   (arb_flit)
    );

    wb_switch_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .wb_in        (wb_in),
        .wb_out       (wb_out),
        .in_status    (in_status),
        .out_status   (out_status),
        .enable       (enable),
        .afull_level  (afull_level),
        .aempty_level (aempty_level)
    );

endmodule

//--- rr_arbiter.sv
// Round-robin mover from input FIFOs to output FIFOs
// One flit every two cycles, routed by the flit's dest field
`timescale 1ns/1ns

module rr_arbiter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  switch_pkg::fifo_status_t         in_status [switch_pkg::NUM_PORTS],
    input  switch_pkg::flit_t                in_flit [switch_pkg::NUM_PORTS],
    output logic [switch_pkg::NUM_PORTS-1:0] in_read,
    input  switch_pkg::fifo_status_t         out_status [switch_pkg::NUM_PORTS],
    output logic [switch_pkg::NUM_PORTS-1:0] out_write,
    output switch_pkg::flit_t                out_flit
);

    switch_pkg::arb_state_e          state;
    logic [switch_pkg::PORT_W-1:0]   last_grant;
    logic [switch_pkg::PORT_W-1:0]   grant;
    logic                            grant_valid;
    logic [switch_pkg::NUM_PORTS-1:0] in_ready;
    logic                            out_paused;
    logic                            issue;

    always_comb begin
        out_paused = 1'b0;
        for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
            in_ready[i] = !in_status[i].empty;
            out_paused = out_paused | out_status[i].pause;
        end
    end

    // First ready input after the last grant in circular order
    always_comb begin : grant_search
        logic [switch_pkg::PORT_W-1:0] idx;
        grant = last_grant;
        grant_valid = 1'b0;
        for (int k = 1; k <= switch_pkg::NUM_PORTS; k++) begin
            idx = last_grant + switch_pkg::PORT_W'(k);
            if (!grant_valid && in_ready[idx]) begin
                grant = idx;
                grant_valid = 1'b1;
            end
        end
    end

    assign issue = (state == switch_pkg::ARB_IDLE) && enable && !out_paused && grant_valid;

    always_comb begin
        in_read = '0;
        if (issue) begin
            in_read[grant] = 1'b1;
        end
    end

    // Granted FIFO's pop register holds the flit during ARB_MOVE
    assign out_flit = in_flit[last_grant];

    always_comb begin
        out_write = '0;
        if (state == switch_pkg::ARB_MOVE) begin
            out_write[out_flit.dest] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= switch_pkg::ARB_IDLE;
            // Port 0 comes first after reset
            last_grant <= switch_pkg::PORT_W'(switch_pkg::NUM_PORTS - 1);
        end else begin
            unique case (state)
                switch_pkg::ARB_IDLE: begin
                    if (issue) begin
                        last_grant <= grant;
                        state <= switch_pkg::ARB_MOVE;
                    end
                end
                switch_pkg::ARB_MOVE: begin
                    state <= switch_pkg::ARB_IDLE;
                end
            endcase
        end
    end

endmodule

//--- switch_pkg.sv
// Packet switch shared definitions
// Flit, FIFO status and Wishbone types, register map and sizes
package switch_pkg;

    // Sizes
    localparam int NUM_PORTS = 4;
    localparam int PORT_W = 2;
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = 3;
    localparam int COUNT_W = 4;
    localparam int FLIT_W = 10;
    localparam int PAYLOAD_W = 8;
    localparam int WB_DATA_W = 16;
    localparam int WB_ADDR_W = 2;

    // Reset levels of the FIFO thresholds
    localparam logic [COUNT_W-1:0] AFULL_RESET = 4'd6;
    localparam logic [COUNT_W-1:0] AEMPTY_RESET = 4'd3;

    // Value returned by the identification register
    localparam logic [WB_DATA_W-1:0] WB_ID_VALUE = 16'h5357;

    // Upper bits select the output port
    typedef struct packed {
        logic [PORT_W-1:0]    dest;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    typedef struct packed {
        logic  write;
        flit_t flit;
    } push_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic almost_full;
        logic almost_empty;
        logic pause;
        logic error;
    } fifo_status_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    // Register addresses
    typedef enum logic [WB_ADDR_W-1:0] {
        REG_CTRL   = 2'd0,
        REG_STATUS = 2'd1,
        REG_ERROR  = 2'd2,
        REG_ID     = 2'd3
    } wb_reg_e;

    typedef enum logic {
        ARB_IDLE,
        ARB_MOVE
    } arb_state_e;

endpackage

//--- tb_packet_switch.sv
// Testbench for the four-port packet switch
// Table-driven pushes, pops and Wishbone accesses checked against a routing scoreboard
`timescale 1ns/1ns

module tb_packet_switch;

    typedef enum {OP_PUSH, OP_POP, OP_WB_WRITE, OP_WB_READ, OP_WAIT_EMPTY_CLEAR} op_e;

    logic                             clk;
    logic                             reset;
    switch_pkg::push_t                push [switch_pkg::NUM_PORTS];
    logic [switch_pkg::NUM_PORTS-1:0] in_pause;
    logic [switch_pkg::NUM_PORTS-1:0] pop_read;
    switch_pkg::flit_t                pop_data [switch_pkg::NUM_PORTS];
    logic [switch_pkg::NUM_PORTS-1:0] pop_empty;
    switch_pkg::wb_req_t              wb_in;
    switch_pkg::wb_rsp_t              wb_out;

    // Stimulus table with one entry per row in each queue
    op_e         op_tab [$];
    int          port_tab [$];
    logic [15:0] data_tab [$];
    logic [15:0] exp_tab [$];
    string       name_tab [$];

    // Expected flits per output port in arrival order
    switch_pkg::flit_t sb_q [switch_pkg::NUM_PORTS][$];
    switch_pkg::flit_t last_pop [switch_pkg::NUM_PORTS];
    logic [31:0]       lfsr = 32'hd6fea56e;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    int                cycle_limit = 0;

    packet_switch DUT (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .in_pause  (in_pause),
        .pop_read  (pop_read),
        .pop_data  (pop_data),
        .pop_empty (pop_empty),
        .wb_in     (wb_in),
        .wb_out    (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles before the table was done", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] value;
        logic       fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            value = {value[6:0], fb};
        end
        return value;
    endfunction

    function automatic void add_row(input op_e op, input int port, input logic [15:0] data,
                                    input logic [15:0] exp_val, input string name);
        op_tab.push_back(op);
        port_tab.push_back(port);
        data_tab.push_back(data);
        exp_tab.push_back(exp_val);
        name_tab.push_back(name);
    endfunction

    // Push data keeps the flit in bits 9:0
    // Bit 15 asks for an LFSR payload, bit 14 marks a push that a full FIFO drops
    function automatic void add_push(input int port, input int dest, input logic [7:0] payload,
                                     input logic random, input logic dropped,
                                     input logic pause, input string name);
        add_row(OP_PUSH, port, {random, dropped, 4'b0, 2'(dest), payload}, {15'b0, pause}, name);
    endfunction

    function automatic void add_drain(input int port, input int count, input string prefix);
        for (int j = 0; j < count; j++) begin
            add_row(OP_WAIT_EMPTY_CLEAR, port, '0, '0,
                    $sformatf("%s_wait_%0d_%0d", prefix, port, j));
            add_row(OP_POP, port, '0, '0, $sformatf("%s_pop_%0d_%0d", prefix, port, j));
        end
    endfunction

    function automatic void build_table();
        add_row(OP_WB_READ, switch_pkg::REG_CTRL, '0, 16'h0361, "reset_ctrl");
        add_row(OP_WB_READ, switch_pkg::REG_STATUS, '0, 16'h00FF, "reset_status");
        add_row(OP_WB_READ, switch_pkg::REG_ERROR, '0, 16'h0000, "reset_error");
        add_row(OP_WB_READ, switch_pkg::REG_ID, '0, 16'h5357, "reset_id");
        // Each round shifts dest by one, so every output gets three flits
        for (int k = 0; k < 12; k++) begin
            add_push(k % 4, (k + k / 4) % 4, 8'h00, 1'b1, 1'b0, 1'b0,
                     $sformatf("route_push_%0d", k));
        end
        for (int d = 0; d < 4; d++) begin
            add_drain(d, 3, "route");
        end
        // Pushed in the order round-robin must deliver them
        add_row(OP_WB_WRITE, switch_pkg::REG_CTRL, 16'h0360, '0, "rr_disable");
        add_push(0, 1, 8'hA1, 1'b0, 1'b0, 1'b0, "rr_push_in0_first");
        add_push(2, 1, 8'hC3, 1'b0, 1'b0, 1'b0, "rr_push_in2_first");
        add_push(0, 1, 8'hB2, 1'b0, 1'b0, 1'b0, "rr_push_in0_second");
        add_push(2, 1, 8'hD4, 1'b0, 1'b0, 1'b0, "rr_push_in2_second");
        add_row(OP_WB_WRITE, switch_pkg::REG_CTRL, 16'h0361, '0, "rr_enable");
        add_drain(1, 4, "rr");
        add_row(OP_WB_WRITE, switch_pkg::REG_CTRL, 16'h0360, '0, "flags_disable");
        for (int k = 1; k <= 6; k++) begin
            add_push(1, 2, 8'h40 + 8'(k), 1'b0, 1'b0, k >= 6, $sformatf("flags_push_%0d", k));
        end
        add_row(OP_WB_WRITE, switch_pkg::REG_CTRL, 16'h0380, '0, "flags_level_8");
        add_push(1, 2, 8'h47, 1'b0, 1'b0, 1'b0, "flags_push_7");
        add_push(1, 2, 8'h48, 1'b0, 1'b0, 1'b1, "flags_push_8");
        add_push(1, 2, 8'h49, 1'b0, 1'b1, 1'b1, "flags_push_dropped");
        add_row(OP_WB_READ, switch_pkg::REG_STATUS, '0, 16'h02FD, "flags_status_full");
        add_row(OP_WB_READ, switch_pkg::REG_ERROR, '0, 16'h0002, "flags_error_input1");
        add_row(OP_WB_WRITE, switch_pkg::REG_CTRL, 16'h0361, '0, "flags_restore");
        add_drain(2, 8, "flags");
        add_row(OP_POP, 3, '0, '0, "err_pop_empty");
        add_row(OP_WB_READ, switch_pkg::REG_ERROR, '0, 16'h0082, "err_sticky");
        add_row(OP_WB_WRITE, switch_pkg::REG_ERROR, 16'h00FF, '0, "err_clear");
        add_row(OP_WB_READ, switch_pkg::REG_ERROR, '0, 16'h0000, "err_cleared");
    endfunction

    task automatic flit_compare(input string name, input switch_pkg::flit_t exp_val,
                                input switch_pkg::flit_t act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic word_compare(input string name, input logic [switch_pkg::WB_DATA_W-1:0] exp_val,
                                input logic [switch_pkg::WB_DATA_W-1:0] act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic flag_compare(input string name, input logic exp_val, input logic act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp_val, act);
        end
    endtask

    task automatic push_flit(input int port, input switch_pkg::flit_t f);
        push[port].write = 1'b1;
        push[port].flit = f;
        @(posedge clk);
        #10;
        push[port] = '0;
    endtask

    task automatic pop_flit(input int port);
        pop_read[port] = 1'b1;
        @(posedge clk);
        #10;
        pop_read[port] = 1'b0;
    endtask

    task automatic wb_access(input logic we, input int adr, input logic [15:0] dat,
                             input string name, output logic [15:0] rd);
        int waited;
        waited = 0;
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we = we;
        wb_in.adr = switch_pkg::WB_ADDR_W'(adr);
        wb_in.dat = dat;
        do begin
            @(posedge clk);
            #10;
            waited++;
        end while (!wb_out.ack && waited < 8);
        if (!wb_out.ack) begin
            errors++;
            $display("%s: no Wishbone ack within %0d cycles", name, waited);
        end
        rd = wb_out.dat;
        wb_in = '0;
    endtask

    task automatic wait_for_data(input int port, input string name);
        int waited;
        waited = 0;
        while (pop_empty[port] && waited < 40) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (pop_empty[port]) begin
            errors++;
            $display("%s: output %0d still empty after %0d cycles", name, port, waited);
        end
    endtask

    initial begin
        switch_pkg::flit_t f;
        switch_pkg::flit_t exp_flit;
        logic [15:0]       rd;
        int                p;
        reset = 1'b0;
        pop_read = '0;
        wb_in = '0;
        for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
            push[i] = '0;
            last_pop[i] = '0;
        end
        build_table();
        cycle_limit = op_tab.size() * 40;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b1;
        for (int r = 0; r < op_tab.size(); r++) begin
            p = port_tab[r];
            case (op_tab[r])
                OP_PUSH: begin
                    f = switch_pkg::flit_t'(data_tab[r][9:0]);
                    if (data_tab[r][15]) begin
                        f.payload = lfsr_bits(8);
                    end
                    push_flit(p, f);
                    if (!data_tab[r][14]) begin
                        sb_q[f.dest].push_back(f);
                    end
                    flag_compare(name_tab[r], exp_tab[r][0], in_pause[p]);
                end
                OP_POP: begin
                    // Nothing expected means an empty pop that leaves the data alone
                    if (sb_q[p].size() > 0) begin
                        exp_flit = sb_q[p].pop_front();
                    end else begin
                        exp_flit = last_pop[p];
                        flag_compare(name_tab[r], 1'b1, pop_empty[p]);
                    end
                    pop_flit(p);
                    flit_compare(name_tab[r], exp_flit, pop_data[p]);
                    last_pop[p] = exp_flit;
                end
                OP_WB_WRITE: wb_access(1'b1, p, data_tab[r], name_tab[r], rd);
                OP_WB_READ: begin
                    wb_access(1'b0, p, '0, name_tab[r], rd);
                    word_compare(name_tab[r], exp_tab[r], rd);
                end
                default: wait_for_data(p, name_tab[r]);
            endcase
        end
        for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
            if (sb_q[i].size() != 0) begin
                errors++;
                $display("Output %0d never delivered %0d expected flits", i, sb_q[i].size());
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- wb_switch_regs.sv
// Wishbone classic register block
// FIFO levels, forwarding enable, flag status and sticky errors
`timescale 1ns/1ns

module wb_switch_regs (
    input  logic                           clk,
    input  logic                           reset,
    input  switch_pkg::wb_req_t            wb_in,
    output switch_pkg::wb_rsp_t            wb_out,
    input  switch_pkg::fifo_status_t       in_status [switch_pkg::NUM_PORTS],
    input  switch_pkg::fifo_status_t       out_status [switch_pkg::NUM_PORTS],
    output logic                           enable,
    output logic [switch_pkg::COUNT_W-1:0] afull_level,
    output logic [switch_pkg::COUNT_W-1:0] aempty_level
);

    logic                               ack;
    logic [switch_pkg::WB_DATA_W-1:0]   rd_data;
    logic [switch_pkg::WB_DATA_W-1:0]   ctrl_word;
    logic [switch_pkg::WB_DATA_W-1:0]   status_word;
    logic [2*switch_pkg::NUM_PORTS-1:0] err_sticky;
    logic [2*switch_pkg::NUM_PORTS-1:0] err_set;
    logic [2*switch_pkg::NUM_PORTS-1:0] err_clear;
    logic                               access;
    logic                               wr_access;
    switch_pkg::wb_reg_e                reg_sel;

    // New request only while ack is low
    assign access = wb_in.cyc && wb_in.stb && !ack;
    assign wr_access = access && wb_in.we;
    assign reg_sel = switch_pkg::wb_reg_e'(wb_in.adr);

    always_comb begin
        ctrl_word = '0;
        ctrl_word[0] = enable;
        ctrl_word[7:4] = afull_level;
        ctrl_word[11:8] = aempty_level;
    end

    // Inputs in the low nibble of each group, outputs above
    always_comb begin
        for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
            status_word[i] = in_status[i].empty;
            status_word[i + switch_pkg::NUM_PORTS] = out_status[i].empty;
            status_word[i + 2*switch_pkg::NUM_PORTS] = in_status[i].full;
            status_word[i + 3*switch_pkg::NUM_PORTS] = out_status[i].full;
            err_set[i] = in_status[i].error;
            err_set[i + switch_pkg::NUM_PORTS] = out_status[i].error;
        end
    end

    // Write one to clear
    assign err_clear = (wr_access && reg_sel == switch_pkg::REG_ERROR)
                       ? wb_in.dat[2*switch_pkg::NUM_PORTS-1:0] : '0;

    always_ff @(posedge clk) begin
        if (!reset) begin
            ack <= 1'b0;
            rd_data <= '0;
            enable <= 1'b1;
            afull_level <= switch_pkg::AFULL_RESET;
            aempty_level <= switch_pkg::AEMPTY_RESET;
            err_sticky <= '0;
        end else begin
            ack <= access;
            // A new error pulse beats a clear
            err_sticky <= (err_sticky & ~err_clear) | err_set;
            if (wr_access && reg_sel == switch_pkg::REG_CTRL) begin
                enable <= wb_in.dat[0];
                afull_level <= wb_in.dat[7:4];
                aempty_level <= wb_in.dat[11:8];
            end
            if (access && !wb_in.we) begin
                unique case (reg_sel)
                    switch_pkg::REG_CTRL:   rd_data <= ctrl_word;
                    switch_pkg::REG_STATUS: rd_data <= status_word;
                    switch_pkg::REG_ERROR:  rd_data <= switch_pkg::WB_DATA_W'(err_sticky);
                    switch_pkg::REG_ID:     rd_data <= switch_pkg::WB_ID_VALUE;
                endcase
            end
        end
    end

    assign wb_out.ack = ack;
    assign wb_out.dat = rd_data;

endmodule
